//--- verilog/sram_pkg.sv
// Shared geometry, width types and controller states for the banked Wishbone SRAM
`default_nettype none

package sram_pkg;

    // Data path
    localparam int DATA_W = 32;               // Bus word width
    localparam int SEL_W = DATA_W / 8;        // One enable per byte lane

    // Address split
    localparam int BANK_AW = 10;              // Words inside one bank
    localparam int BANK_SEL_W = 2;            // Bank index bits
    localparam int BANK_COUNT = 4;
    localparam int ADDR_W = BANK_AW + BANK_SEL_W;
    localparam int BANK_DEPTH = 1 << BANK_AW; // 1024 words per bank

    // Widths that carry a meaning
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [SEL_W-1:0] sel_t;
    typedef logic [ADDR_W-1:0] addr_t;        // Word address, not byte
    typedef logic [BANK_AW-1:0] bank_addr_t;
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;

    // Wishbone slave FSM
    typedef enum logic [0:0] {
        IDLE = 1'b0,                          // Waiting for cyc and stb
        ACK  = 1'b1                           // Ack on the bus this cycle
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/sram_bank.sv
// One SRAM bank with byte-lane writes and a registered read port
`timescale 1ns/1ps
`default_nettype none

module sram_bank
    import sram_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       en,     // One access this edge
    input  wire bank_addr_t addr,
    input  wire sel_t       wr,     // Byte write enables, zero for a read
    input  wire word_t      wdata,
    output word_t           rdata
);

    // Two-state storage, powers up as all zero
    bit [DATA_W-1:0] mem [BANK_DEPTH];

    // Read register, also two-state so idle banks drive zero
    bit [DATA_W-1:0] rd_q;

    // Write side
    // Each lane is written only when its enable bit is set
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (wr[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read side
    // Captures the word as it was before this edge's write,
    // held until the next enabled edge
    always_ff @(posedge clk) begin
        if (en) begin
            rd_q <= mem[addr];      // Old data, read-first
        end
    end

    assign rdata = rd_q;

endmodule

`default_nettype wire

//--- verilog/sram_array.sv
// Four-bank SRAM array with bank decode and a registered read-data select
`timescale 1ns/1ps
`default_nettype none

module sram_array
    import sram_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  mem_en,
    input  wire addr_t mem_addr,
    input  wire sel_t  mem_wr,
    input  wire word_t mem_wdata,
    output word_t      mem_rdata
);

    bank_sel_t              bank_idx;   // Upper word-address bits
    bank_addr_t             bank_addr;  // Lower bits, shared by all banks
    logic [BANK_COUNT-1:0]  bank_hot;   // One-hot decode of bank_idx
    logic [BANK_COUNT-1:0]  bank_sel_q; // Decode from the last enabled edge
    word_t                  bank_rdata [BANK_COUNT];

    assign bank_idx  = mem_addr[ADDR_W-1 -: BANK_SEL_W];
    assign bank_addr = mem_addr[BANK_AW-1:0];

    // Bank decode
    always_comb begin
        bank_hot = '0;
        bank_hot[bank_idx] = 1'b1;
    end

    // Only the addressed bank sees enable
    for (genvar g = 0; g < BANK_COUNT; g++) begin : g_bank
        sram_bank bank_i (
            .clk   (clk),
            .en    (mem_en & bank_hot[g]),
            .addr  (bank_addr),
            .wr    (mem_wr),
            .wdata (mem_wdata),
            .rdata (bank_rdata[g])
        );
    end

    // Bank select follows the bank's own read register
    // so the mux points at the bank that was read one cycle ago
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_sel_q <= BANK_COUNT'(1);   // Bank 0
        end else if (mem_en) begin
            bank_sel_q <= bank_hot;
        end
    end

    // AND-OR read mux
    always_comb begin
        mem_rdata = '0;
        for (int i = 0; i < BANK_COUNT; i++) begin
            mem_rdata = mem_rdata | (bank_rdata[i] & {DATA_W{bank_sel_q[i]}});
        end
    end

endmodule

`default_nettype wire

//--- verilog/wb_sram_ctrl.sv
// Wishbone classic slave FSM that turns each bus cycle into one memory access
`timescale 1ns/1ps
`default_nettype none

module wb_sram_ctrl
    import sram_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,

    // Wishbone classic slave
    input  wire logic  cyc,
    input  wire logic  stb,
    input  wire logic  we,
    input  wire addr_t adr,         // Word address
    input  wire sel_t  sel,
    input  wire word_t dat_w,
    output logic       ack,
    output word_t      dat_r,

    // Memory port
    output logic       mem_en,
    output addr_t      mem_addr,
    output sel_t       mem_wr,      // Byte write enables
    output word_t      mem_wdata,
    input  wire word_t mem_rdata
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        req;               // Request seen on the bus

    assign req = cyc & stb;

    // Next state
    // A request in IDLE is done in one edge, ACK always goes back to IDLE
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                state_d = IDLE;     // A held request is taken again from IDLE
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Memory access
    // Issued in the same cycle the request is seen, never while in ACK
    assign mem_en    = (state_q == IDLE) & req;
    assign mem_addr  = adr;
    assign mem_wdata = dat_w;

    // Reads must not touch the array
    always_comb begin
        if (we) begin
            mem_wr = sel;
        end else begin
            mem_wr = '0;
        end
    end

    // Ack comes straight from the state register
    // High for exactly the cycle after the accepting edge
    assign ack = (state_q == ACK);

    // Array output is already one cycle late, which lines up with ack
    assign dat_r = mem_rdata;       // Valid only with ack

endmodule

`default_nettype wire

//--- verilog/wb_sram_top.sv
// Top level of the banked SRAM with a Wishbone classic slave port
`timescale 1ns/1ps
`default_nettype none

module wb_sram_top
    import sram_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  cyc,
    input  wire logic  stb,
    input  wire logic  we,
    input  wire addr_t adr,
    input  wire sel_t  sel,
    input  wire word_t dat_w,
    output logic       ack,
    output word_t      dat_r
);

    // Controller to array
    logic  mem_en;
    addr_t mem_addr;
    sel_t  mem_wr;
    word_t mem_wdata;
    word_t mem_rdata;

    wb_sram_ctrl ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .sel       (sel),
        .dat_w     (dat_w),
        .ack       (ack),
        .dat_r     (dat_r),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    sram_array array_i (
        .clk       (clk),
        .reset     (reset),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- tb/wb_sram_asserts.sv
// Concurrent checks on the Wishbone ack handshake of the SRAM top level
`timescale 1ns/1ps
`default_nettype none

module wb_sram_asserts
    import sram_pkg::*;
(
    input wire logic  clk,
    input wire logic  reset,
    input wire logic  cyc,
    input wire logic  stb,
    input wire logic  ack
);

    int fail_count = 0;     // Failed assertions, polled by the testbench

    // Reset leaves the slave quiet
    ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack)
        else begin fail_count++; $error("ack high in the cycle after reset"); end

    // One ack cycle per request
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else begin fail_count++; $error("ack high for two cycles in a row"); end

    // ack only answers a request taken while ack was low
    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        ack |-> $past(cyc && stb && !ack))
        else begin fail_count++; $error("ack rose without a request"); end

endmodule

bind wb_sram_top wb_sram_asserts asserts_i (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack)
);

`default_nettype wire

//--- tb/wb_sram_tb.sv
// Testbench for the banked Wishbone SRAM, random master against a shadow memory
`timescale 1ns/1ps
`default_nettype none

module wb_sram_tb
    import sram_pkg::*;
();

    localparam int SEED        = 67031;
    localparam int ACK_TIMEOUT = 20;            // Edges to wait for ack
    localparam int ACK_EDGES   = 2;             // Accepting edge, then the ack cycle
    localparam int MEM_WORDS   = 1 << ADDR_W;   // 4096 words over all banks

    logic  clk;
    logic  reset;
    logic  cyc;
    logic  stb;
    logic  we;
    addr_t adr;
    sel_t  sel;
    word_t dat_w;
    logic  ack;
    word_t dat_r;

    word_t model_mem [MEM_WORDS];               // Shadow copy of the SRAM

    wb_sram_top dut_i (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .sel   (sel),
        .dat_w (dat_w),
        .ack   (ack),
        .dat_r (dat_r)
    );

    always #4 clk = ~clk;                       // 8 ns period

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // Byte lanes under s take the new data, the rest keep the old word
    function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input sel_t s);
        word_t res;
        res = old_w;
        for (int i = 0; i < SEL_W; i++) begin
            if (s[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return res;
    endfunction

    // One Wishbone classic cycle, called right after a rising edge
    task automatic bus_xfer(input logic wr, input addr_t a, input sel_t s, input word_t d,
                            input bit no_gap, output word_t rdata);
        int cycles;
        int gap;
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        sel   <= s;
        dat_w <= d;
        cycles = 0;
        do begin
            @(posedge clk);                     // ack seen here is the value of the past cycle
            cycles++;
        end while (ack !== 1'b1 && cycles < ACK_TIMEOUT);
        if (ack !== 1'b1) begin
            $display("Timeout: ack never arrived for the request at word address 0x%0h", a);
            $display("Simulation FAILED");
            $fatal(1);
        end
        check_value(cycles, ACK_EDGES, $sformatf("edges from request to ack at 0x%0h", a));
        rdata = dat_r;                          // Held through the ack cycle
        if (wr) model_mem[a] = merge_lanes(model_mem[a], d, s);
        gap = no_gap ? 0 : $urandom_range(2, 0);
        if (gap > 0) begin
            cyc <= 1'b0;
            stb <= 1'b0;
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic read_check(input addr_t a, input bit no_gap);
        word_t rd;
        bus_xfer(1'b0, a, sel_t'($urandom), '0, no_gap, rd);   // sel is ignored on reads
        check_value(rd, model_mem[a], $sformatf("read data at 0x%0h", a));
    endtask

    task automatic write_word(input addr_t a, input sel_t s, input word_t d);
        word_t rd;
        bus_xfer(1'b1, a, s, d, 1'b0, rd);
    endtask

    task automatic bus_idle();
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    initial begin
        addr_t a;
        addr_t bank_word [BANK_COUNT];          // One test word per bank
        int    b;
        int    prev_b;
        void'($urandom(SEED));
        clk = 1'b0;
        reset <= 1'b1;
        cyc   <= 1'b0;
        stb   <= 1'b0;
        we    <= 1'b0;
        adr   <= '0;
        sel   <= '0;
        dat_w <= '0;
        for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Idle bus, no ack
        repeat (6) begin
            @(posedge clk);
            check_value(ack, 1'b0, "ack while the bus is idle");
        end

        // Fresh memory reads back as zero
        repeat (20) read_check(addr_t'($urandom), 1'b0);

        // Full-word write then read, all banks
        repeat (40) begin
            a = addr_t'($urandom);
            write_word(a, '1, word_t'($urandom));
            read_check(a, 1'b0);
        end

        // Partial writes over known data, sel of zero included
        repeat (60) begin
            a = addr_t'($urandom);
            write_word(a, '1, word_t'($urandom));
            write_word(a, sel_t'($urandom_range(15, 0)), word_t'($urandom));
            read_check(a, 1'b0);
        end

        // Back-to-back reads hopping between banks
        for (int i = 0; i < BANK_COUNT; i++) begin
            bank_word[i] = {bank_sel_t'(i), bank_addr_t'($urandom)};
            write_word(bank_word[i], '1, word_t'($urandom));
        end
        prev_b = 0;
        repeat (24) begin
            b = (prev_b + 1 + $urandom_range(2, 0)) % BANK_COUNT;   // Never the same bank
            read_check(bank_word[b], 1'b1);
            prev_b = b;
        end
        bus_idle();
        repeat (3) @(posedge clk);

        if (dut_i.asserts_i.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- all.f
verilog/sram_pkg.sv
verilog/sram_bank.sv
verilog/sram_array.sv
verilog/wb_sram_ctrl.sv
verilog/wb_sram_top.sv
tb/wb_sram_asserts.sv
tb/wb_sram_tb.sv
